//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_dual_uart_rx
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- design/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter logic [15:0] CLKS_PER_TICK = 16'd27
) (
    input  logic i_clock,
    input  logic i_reset,
    output logic o_tick
);

    logic [15:0] count;

    // The counter wraps from zero to CLKS_PER_TICK-1 and the tick is
    // registered on the step down to zero, so the first tick lands
    // CLKS_PER_TICK clocks after reset is released.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else begin
            if (count == 16'd0) begin
                count <= CLKS_PER_TICK - 16'd1;
            end else begin
                count <= count - 16'd1;
            end
            o_tick <= (count == 16'd1);   // High while the count sits at zero
        end
    end

endmodule

//--- design/dual_uart_rx_top.sv
`timescale 1ns/1ps

module dual_uart_rx_top import uart_rx_pkg::*; #(
    parameter logic [15:0] CLKS_PER_TICK = 16'd27
) (
    input  logic  i_clock,
    input  logic  i_reset,
    input  logic  i_rx0,
    input  logic  i_rx1,
    output logic  o_valid,
    output byte_t o_data,
    output chan_t o_channel,
    output logic  o_frame_error
);

    logic  s_tick;
    logic  s_done0, s_done1;
    byte_t s_data0, s_data1;
    logic  s_error0, s_error1;

    baud_tick_gen #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) u_tick (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .o_tick  (s_tick)
    );

    // Both receivers share one tick, so they sample in lockstep
    rx_uart u_rx0 (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_rx          (i_rx0),
        .i_tick        (s_tick),
        .o_done        (s_done0),
        .o_data        (s_data0),
        .o_frame_error (s_error0)
    );

    rx_uart u_rx1 (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_rx          (i_rx1),
        .i_tick        (s_tick),
        .o_done        (s_done1),
        .o_data        (s_data1),
        .o_frame_error (s_error1)
    );

    rx_merge u_merge (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_done0       (s_done0),
        .i_data0       (s_data0),
        .i_error0      (s_error0),
        .i_done1       (s_done1),
        .i_data1       (s_data1),
        .i_error1      (s_error1),
        .o_valid       (o_valid),
        .o_data        (o_data),
        .o_channel     (o_channel),
        .o_frame_error (o_frame_error)
    );

endmodule

//--- design/rx_merge.sv
`timescale 1ns/1ps

module rx_merge import uart_rx_pkg::*; (
    input  logic  i_clock,
    input  logic  i_reset,
    input  logic  i_done0,
    input  byte_t i_data0,
    input  logic  i_error0,
    input  logic  i_done1,
    input  byte_t i_data1,
    input  logic  i_error1,
    output logic  o_valid,
    output byte_t o_data,
    output chan_t o_channel,
    output logic  o_frame_error
);

    logic  pending_full;
    byte_t pending_data;
    logic  pending_error;

    // ########################################
    // Control
    // ########################################

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid      <= 1'b0;
            pending_full <= 1'b0;
        end else begin
            o_valid <= i_done0 | i_done1 | pending_full;
            if (i_done0) begin
                pending_full <= i_done1;   // Channel 1 waits one cycle on a collision
            end else if (pending_full) begin
                pending_full <= i_done1;
            end
        end
    end

    // ########################################
    // Payload
    // ########################################

    always_ff @(posedge i_clock) begin
        if (i_done0) begin
            o_data        <= i_data0;
            o_frame_error <= i_error0;
            o_channel     <= chan_t'(0);
        end else if (pending_full) begin
            o_data        <= pending_data;
            o_frame_error <= pending_error;
            o_channel     <= chan_t'(1);
        end else if (i_done1) begin
            o_data        <= i_data1;
            o_frame_error <= i_error1;
            o_channel     <= chan_t'(1);
        end

        // The pending slot only fills while it is busy or channel 0 takes the output
        if (i_done1 && (i_done0 || pending_full)) begin
            pending_data  <= i_data1;
            pending_error <= i_error1;
        end
    end

endmodule

//--- design/rx_uart.sv
`timescale 1ns/1ps

module rx_uart import uart_rx_pkg::*; (
    input  logic  i_clock,
    input  logic  i_reset,
    input  logic  i_rx,
    input  logic  i_tick,
    output logic  o_done,
    output byte_t o_data,
    output logic  o_frame_error
);

    rx_state_t   state, next_state;
    tick_count_t tick_count, next_tick_count;
    bit_count_t  bit_count, next_bit_count;
    byte_t       shift_q, next_shift;
    logic        frame_error_q, next_frame_error;

    // ########################################
    // State registers
    // ########################################

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state         <= RX_IDLE;
            tick_count    <= '0;
            bit_count     <= '0;
            shift_q       <= '0;
            frame_error_q <= 1'b0;
        end else begin
            state         <= next_state;
            tick_count    <= next_tick_count;
            bit_count     <= next_bit_count;
            shift_q       <= next_shift;
            frame_error_q <= next_frame_error;
        end
    end

    // ########################################
    // Next state
    // ########################################

    always_comb begin
        next_state       = state;
        next_tick_count  = tick_count;
        next_bit_count   = bit_count;
        next_shift       = shift_q;
        next_frame_error = frame_error_q;
        o_done           = 1'b0;

        case (state)
            RX_IDLE: begin
                if (!i_rx) begin                // Falling edge opens a frame
                    next_state      = RX_START;
                    next_tick_count = '0;
                end
            end
            RX_START: begin
                if (i_tick) begin
                    if (tick_count == tick_count_t'(START_MID_TICK)) begin
                        next_tick_count = '0;
                        next_bit_count  = '0;
                        if (i_rx) begin
                            next_state = RX_IDLE;   // Glitch, not a real start bit
                        end else begin
                            next_state = RX_DATA;
                        end
                    end else begin
                        next_tick_count = tick_count + tick_count_t'(1);
                    end
                end
            end
            RX_DATA: begin
                if (i_tick) begin
                    if (tick_count == tick_count_t'(TICKS_PER_BIT - 1)) begin
                        next_tick_count = '0;
                        next_shift      = {i_rx, shift_q[7:1]};   // LSB arrives first
                        if (bit_count == bit_count_t'($bits(byte_t) - 1)) begin
                            next_state = RX_STOP;
                        end else begin
                            next_bit_count = bit_count + bit_count_t'(1);
                        end
                    end else begin
                        next_tick_count = tick_count + tick_count_t'(1);
                    end
                end
            end
            RX_STOP: begin
                if (i_tick) begin
                    if (tick_count == tick_count_t'(TICKS_PER_BIT - 1)) begin
                        next_state       = RX_IDLE;
                        next_frame_error = ~i_rx;   // Stop bit must be high
                        o_done           = 1'b1;
                    end else begin
                        next_tick_count = tick_count + tick_count_t'(1);
                    end
                end
            end
            default: begin
                next_state = RX_IDLE;
            end
        endcase
    end

    assign o_data = shift_q;

    // The live stop sample covers the done cycle and the register holds it after
    assign o_frame_error = o_done ? ~i_rx : frame_error_q;

endmodule

//--- design/uart_rx_pkg.sv
package uart_rx_pkg;

    // ########################################
    // Widths
    // ########################################

    typedef logic [7:0] byte_t;         // One received data byte
    typedef logic [3:0] tick_count_t;   // Oversampling ticks within one bit
    typedef logic [2:0] bit_count_t;    // Index of the data bit in flight
    typedef logic       chan_t;         // Source channel of an output byte

    // ########################################
    // Receiver FSM
    // ########################################

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    localparam int TICKS_PER_BIT  = 16;   // 16x oversampling
    localparam int START_MID_TICK = 7;    // Middle of the start bit

endpackage

//--- dv/tb_dual_uart_rx.sv
`timescale 1ns/1ps

module tb_dual_uart_rx import uart_rx_pkg::*; ();

    localparam int CLK_PERIOD     = 10;
    localparam int TICK_CLOCKS    = 4;
    localparam int BIT_CLOCKS     = TICK_CLOCKS * TICKS_PER_BIT;   // 64 clocks per bit
    localparam int FRAME_CLOCKS   = 10 * BIT_CLOCKS;
    localparam int RESET_CYCLES   = 5;
    localparam int RANDOM_FRAMES  = 20;
    localparam int FRAME_COUNT    = 7 + 2 * RANDOM_FRAMES;       // All frames of all tests
    localparam int WATCHDOG_CLKS  = FRAME_COUNT * FRAME_CLOCKS * 2;
    localparam int STROBE_TIMEOUT = 2 * FRAME_CLOCKS;
    localparam int SETTLE_CLOCKS  = 2 * BIT_CLOCKS;

    logic  clock = 1'b0;
    logic  reset;
    logic  rx0;
    logic  rx1;
    logic  valid;
    byte_t data;
    chan_t channel;
    logic  frame_error;

    int          cycle = 0;
    int          release_cycle = 0;
    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] lfsr_state = 32'hfa27004c;

    byte_t seen_data[$];
    chan_t seen_chan[$];
    logic  seen_err[$];
    int    seen_cycle[$];

    dual_uart_rx_top #(
        .CLKS_PER_TICK(16'd4)
    ) i_dut (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_rx0         (rx0),
        .i_rx1         (rx1),
        .o_valid       (valid),
        .o_data        (data),
        .o_channel     (channel),
        .o_frame_error (frame_error)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (valid) begin
            seen_data.push_back(data);
            seen_chan.push_back(channel);
            seen_err.push_back(frame_error);
            seen_cycle.push_back(cycle);
        end
    end

    // ########################################
    // Helpers
    // ########################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};   // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_failure(input string message);
        error_count++;
        $display("%s at %0t", message, $time);
    endtask

    task automatic drive_line(input int chan, input logic level);
        if (chan == 0) begin
            rx0 <= level;
        end else begin
            rx1 <= level;
        end
    endtask

    task automatic send_frame(input int chan, input byte_t value, input logic stop_level);
        logic [9:0] bits;
        bits = {stop_level, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            drive_line(chan, bits[i]);
            repeat (BIT_CLOCKS - 1) @(posedge clock);
        end
        @(posedge clock);
        drive_line(chan, 1'b1);   // Back to idle after a low stop bit
    endtask

    // Returns so that the next edge starts a frame one clock before a tick
    task automatic align_to_tick();
        @(posedge clock);
        while (((cycle - release_cycle) % TICK_CLOCKS) != TICK_CLOCKS - 1) begin
            @(posedge clock);
        end
    endtask

    task automatic clear_seen();
        seen_data.delete();
        seen_chan.delete();
        seen_err.delete();
        seen_cycle.delete();
    endtask

    task automatic collect_strobes(input int count, input string test);
        int waited;
        waited = 0;
        while (seen_data.size() < count && waited < STROBE_TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        repeat (SETTLE_CLOCKS) @(posedge clock);   // Room for any extra strobe to show up
        if (seen_data.size() < count) begin
            report_failure($sformatf("%s: only %0d of %0d output strobes arrived",
                                     test, seen_data.size(), count));
        end else if (seen_data.size() > count) begin
            report_failure($sformatf("%s: %0d output strobes arrived where %0d were expected",
                                     test, seen_data.size(), count));
        end
    endtask

    task automatic expect_strobe(input int idx, input byte_t exp_data, input chan_t exp_chan,
                                 input logic exp_error);
        if (idx < seen_data.size()) begin
            check_value("o_data", 32'(exp_data), 32'(seen_data[idx]));
            check_value("o_channel", 32'(exp_chan), 32'(seen_chan[idx]));
            check_value("o_frame_error", 32'(exp_error), 32'(seen_err[idx]));
        end
    endtask

    // ########################################
    // Tests
    // ########################################

    task automatic test_reset_idle();
        reset <= 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clock);
            if (i > 0) begin
                check_value("o_valid", 32'h0, 32'(valid));
            end
        end
        reset <= 1'b0;
        release_cycle = cycle;
        clear_seen();
        repeat (1000) @(posedge clock);
        collect_strobes(0, "reset and idle");
    endtask

    task automatic test_single_channel();
        clear_seen();
        send_frame(0, 8'hA5, 1'b1);
        send_frame(1, 8'h3C, 1'b1);
        collect_strobes(2, "single channel");
        expect_strobe(0, 8'hA5, 1'b0, 1'b0);
        expect_strobe(1, 8'h3C, 1'b1, 1'b0);
    endtask

    task automatic test_simultaneous();
        clear_seen();
        fork
            send_frame(0, 8'h81, 1'b1);
            send_frame(1, 8'h7E, 1'b1);
        join
        collect_strobes(2, "simultaneous frames");
        expect_strobe(0, 8'h81, 1'b0, 1'b0);
        expect_strobe(1, 8'h7E, 1'b1, 1'b0);
        if (seen_cycle.size() == 2) begin
            check_value("o_valid spacing", 32'd1, 32'(seen_cycle[1] - seen_cycle[0]));
        end
    endtask

    task automatic test_framing_error();
        clear_seen();
        align_to_tick();   // The low stop bit then ends before the receiver looks again
        send_frame(0, 8'hC3, 1'b0);
        repeat (FRAME_CLOCKS) @(posedge clock);
        send_frame(0, 8'h96, 1'b1);
        collect_strobes(2, "framing error");
        expect_strobe(0, 8'hC3, 1'b0, 1'b1);
        expect_strobe(1, 8'h96, 1'b0, 1'b0);
    endtask

    task automatic test_false_start();
        clear_seen();
        @(posedge clock);
        rx0 <= 1'b0;
        repeat (2 * TICK_CLOCKS) @(posedge clock);
        rx0 <= 1'b1;
        repeat (BIT_CLOCKS) @(posedge clock);
        send_frame(0, 8'h5A, 1'b1);
        collect_strobes(1, "false start");
        expect_strobe(0, 8'h5A, 1'b0, 1'b0);
    endtask

    task automatic test_random_traffic();
        byte_t exp0[$];
        byte_t exp1[$];
        byte_t b0;
        byte_t b1;
        int    offset;
        int    n0;
        int    n1;
        clear_seen();
        for (int i = 0; i < RANDOM_FRAMES; i++) begin
            b0     = byte_t'(random_bits(8));
            b1     = byte_t'(random_bits(8));
            offset = int'(random_bits(6));
            exp0.push_back(b0);
            exp1.push_back(b1);
            fork
                send_frame(0, b0, 1'b1);
                begin
                    repeat (offset) @(posedge clock);
                    send_frame(1, b1, 1'b1);
                end
            join
        end
        collect_strobes(2 * RANDOM_FRAMES, "random traffic");
        n0 = 0;
        n1 = 0;
        for (int k = 0; k < seen_data.size(); k++) begin
            check_value("o_frame_error", 32'h0, 32'(seen_err[k]));
            if (seen_chan[k] == 1'b0) begin
                if (n0 < exp0.size()) begin
                    check_value("o_data", 32'(exp0[n0]), 32'(seen_data[k]));
                end
                n0++;
            end else begin
                if (n1 < exp1.size()) begin
                    check_value("o_data", 32'(exp1[n1]), 32'(seen_data[k]));
                end
                n1++;
            end
        end
        if (n0 != exp0.size() || n1 != exp1.size()) begin
            report_failure($sformatf("random traffic: %0d and %0d bytes arrived, not %0d each",
                                     n0, n1, RANDOM_FRAMES));
        end
    endtask

    // ########################################
    // Sequence
    // ########################################

    initial begin
        reset <= 1'b1;
        rx0   <= 1'b1;
        rx1   <= 1'b1;
        test_reset_idle();
        test_single_channel();
        test_simultaneous();
        test_framing_error();
        test_false_start();
        test_random_traffic();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CLKS * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clocks", WATCHDOG_CLKS);
        $display("Test failed");
        $finish;
    end

endmodule

//--- vlog.f
design/uart_rx_pkg.sv
design/baud_tick_gen.sv
design/rx_uart.sv
design/rx_merge.sv
design/dual_uart_rx_top.sv
dv/tb_dual_uart_rx.sv
